// ==== source/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    // ============================================================
    // Register map
    // ============================================================
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_COUNT  = 8'h08;
    localparam logic [7:0] REG_LIMIT  = 8'h0C;
    localparam logic [7:0] REG_DROPS  = 8'h10;

    // Master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== source/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

    // ============================================================
    // Audio sizes
    // ============================================================
    localparam int SAMPLE_BITS = 16;
    localparam int ADDR_BITS   = 20;

    localparam logic [ADDR_BITS-1:0] LIMIT_RESET = 20'd1024000;

    // One-cycle command pulses
    typedef struct packed {
        logic start;
        logic pause;
        logic stop;
    } aud_cmd_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0]   addr;
        logic [SAMPLE_BITS-1:0] data;
    } sample_t;

    // count is also the next write address
    typedef struct packed {
        logic                 recording;
        logic                 paused;
        logic                 done;
        logic [ADDR_BITS-1:0] count;
    } rec_status_t;

    typedef struct packed {
        logic                   we;
        logic [ADDR_BITS-1:0]   addr;
        logic [SAMPLE_BITS-1:0] data;
    } sram_wr_t;

endpackage

`default_nettype wire

// ==== source/aud_ctrl_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module aud_ctrl_regs
    import apb_pkg::*;
    import aud_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire apb_req_t    i_apb,
    input  wire rec_status_t i_status,
    input  wire logic [15:0] i_drops,
    output apb_rsp_t         o_apb,
    output aud_cmd_t         o_cmd,
    output logic [19:0]      o_limit
);

    logic                 access;
    logic                 addr_err;
    logic                 wr_ok;
    logic [31:0]          rdata;
    aud_cmd_t             cmd_r;
    logic [ADDR_BITS-1:0] limit_r;

    // Access phase, no wait states
    assign access = i_apb.psel & i_apb.penable;
    assign wr_ok  = access & i_apb.pwrite & ~addr_err;

    // ============================================================
    // Address decode and read mux
    // ============================================================
    always_comb begin
        rdata    = '0;
        addr_err = 1'b0;
        case (i_apb.paddr)
            REG_CTRL: begin
                rdata = '0;
            end
            REG_STATUS: begin
                rdata    = {29'd0, i_status.done, i_status.paused, i_status.recording};
                addr_err = i_apb.pwrite;
            end
            REG_COUNT: begin
                rdata    = {{(32-ADDR_BITS){1'b0}}, i_status.count};
                addr_err = i_apb.pwrite;
            end
            REG_LIMIT: begin
                rdata = {{(32-ADDR_BITS){1'b0}}, limit_r};
            end
            REG_DROPS: begin
                rdata    = {16'd0, i_drops};
                addr_err = i_apb.pwrite;
            end
            default: begin
                addr_err = 1'b1;
            end
        endcase
    end

    always_comb begin
        o_apb.pready  = access;
        o_apb.pslverr = access & addr_err;
        o_apb.prdata  = rdata;
    end

    // ============================================================
    // Writable state
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            cmd_r   <= '0;
            limit_r <= LIMIT_RESET;
        end else begin
            // Pulses last one cycle only
            cmd_r <= '0;
            if (wr_ok && i_apb.paddr == REG_CTRL) begin
                cmd_r.start <= i_apb.pwdata[0];
                cmd_r.pause <= i_apb.pwdata[1];
                cmd_r.stop  <= i_apb.pwdata[2];
            end
            if (wr_ok && i_apb.paddr == REG_LIMIT) begin
                limit_r <= i_apb.pwdata[ADDR_BITS-1:0];
            end
        end
    end

    assign o_cmd   = cmd_r;
    assign o_limit = limit_r;

endmodule

`default_nettype wire

// ==== source/aud_recorder.sv ====
`default_nettype none
`timescale 1ns/1ps

module aud_recorder
    import aud_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_lrc,
    input  wire logic        i_data,
    input  wire aud_cmd_t    i_cmd,
    input  wire logic [19:0] i_limit,
    output sample_t          o_sample,
    output logic             o_sample_valid,
    output rec_status_t      o_status
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_SHIFT,
        S_DONE
    } state_t;

    state_t                 state_r, state_w;
    logic [ADDR_BITS-1:0]   addr_r, addr_w;
    logic [ADDR_BITS-1:0]   addr_inc;
    logic [4:0]             bit_cnt_r, bit_cnt_w;
    logic                   paused_r, paused_w;
    logic                   valid_r, valid_w;
    logic                   lrc_d_r;
    logic                   word_start;
    logic                   recording;
    logic [SAMPLE_BITS-1:0] shift_r;
    sample_t                sample_r;

    // LRC falling edge; bit 15 follows one cycle later
    assign word_start = lrc_d_r & ~i_lrc;
    assign recording  = (state_r == S_WAIT) || (state_r == S_SHIFT);
    assign addr_inc   = addr_r + 1'b1;

    // ============================================================
    // Next state
    // ============================================================
    always_comb begin
        state_w   = state_r;
        addr_w    = addr_r;
        bit_cnt_w = bit_cnt_r;
        paused_w  = paused_r;
        valid_w   = 1'b0;
        case (state_r)
            S_IDLE: begin
                state_w = S_IDLE;
            end
            S_WAIT: begin
                if (addr_r >= i_limit) begin
                    state_w = S_DONE;
                end else if (word_start && !paused_r) begin
                    state_w   = S_SHIFT;
                    bit_cnt_w = 5'd0;
                end
            end
            S_SHIFT: begin
                bit_cnt_w = bit_cnt_r + 5'd1;
                // Last bit of the word
                if (bit_cnt_r == 5'd15) begin
                    valid_w = 1'b1;
                    addr_w  = addr_inc;
                    state_w = (addr_inc >= i_limit) ? S_DONE : S_WAIT;
                end
            end
            S_DONE: begin
                state_w = S_DONE;
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase

        // Commands, start has the last word
        if (i_cmd.pause && recording) begin
            paused_w = ~paused_r;
        end
        if (i_cmd.stop && recording) begin
            state_w = S_DONE;
            addr_w  = addr_r;
            valid_w = 1'b0;
        end
        if (i_cmd.start) begin
            state_w  = S_WAIT;
            addr_w   = '0;
            paused_w = 1'b0;
            valid_w  = 1'b0;
        end
        if (state_w == S_DONE) begin
            paused_w = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= S_IDLE;
            addr_r    <= '0;
            bit_cnt_r <= '0;
            paused_r  <= 1'b0;
            valid_r   <= 1'b0;
            lrc_d_r   <= 1'b0;
        end else begin
            state_r   <= state_w;
            addr_r    <= addr_w;
            bit_cnt_r <= bit_cnt_w;
            paused_r  <= paused_w;
            valid_r   <= valid_w;
            lrc_d_r   <= i_lrc;
        end
    end

    // Shift register and sample payload
    always_ff @(posedge i_clk) begin
        if (state_r == S_SHIFT) begin
            shift_r <= {shift_r[SAMPLE_BITS-2:0], i_data};
        end
        if (valid_w) begin
            sample_r.addr <= addr_r;
            sample_r.data <= {shift_r[SAMPLE_BITS-2:0], i_data};
        end
    end

    assign o_sample       = sample_r;
    assign o_sample_valid = valid_r;

    always_comb begin
        o_status.recording = recording;
        o_status.paused    = paused_r;
        o_status.done      = (state_r == S_DONE);
        o_status.count     = addr_r;
    end

endmodule

`default_nettype wire

// ==== source/sram_writer.sv ====
`default_nettype none
`timescale 1ns/1ps

module sram_writer
    import aud_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire sample_t i_sample,
    input  wire logic    i_sample_valid,
    input  wire logic    i_sram_ready,
    output sram_wr_t     o_sram,
    output logic [15:0]  o_drops
);

    sample_t     hold_r;
    logic        we_r;
    logic [15:0] drops_r;
    logic        accept;
    logic        load;
    logic        drop;

    // ============================================================
    // Holding stage control
    // ============================================================
    assign accept = we_r & i_sram_ready;

    // Slot is free when empty or draining this cycle
    assign load = i_sample_valid & (~we_r | accept);
    assign drop = i_sample_valid & we_r & ~i_sram_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            we_r    <= 1'b0;
            drops_r <= '0;
        end else begin
            if (load) begin
                we_r <= 1'b1;
            end else if (accept) begin
                we_r <= 1'b0;
            end
            // Saturates at all ones
            if (drop && drops_r != 16'hFFFF) begin
                drops_r <= drops_r + 16'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            hold_r <= i_sample;
        end
    end

    // ============================================================
    // SRAM port
    // ============================================================
    always_comb begin
        o_sram.we   = we_r;
        o_sram.addr = hold_r.addr;
        o_sram.data = hold_r.data;
    end

    assign o_drops = drops_r;

endmodule

`default_nettype wire

// ==== source/aud_rec_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module aud_rec_top
    import apb_pkg::*;
    import aud_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire apb_req_t i_apb,
    output apb_rsp_t      o_apb,
    input  wire logic     i_lrc,
    input  wire logic     i_data,
    output sram_wr_t      o_sram,
    input  wire logic     i_sram_ready
);

    aud_cmd_t             cmd;
    rec_status_t          status;
    logic [ADDR_BITS-1:0] limit;
    sample_t              sample;
    logic                 sample_valid;
    logic [15:0]          drops;

    // Register block
    aud_ctrl_regs aud_ctrl_regs_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_apb    (i_apb),
        .i_status (status),
        .i_drops  (drops),
        .o_apb    (o_apb),
        .o_cmd    (cmd),
        .o_limit  (limit)
    );

    // I2S capture
    aud_recorder aud_recorder_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lrc          (i_lrc),
        .i_data         (i_data),
        .i_cmd          (cmd),
        .i_limit        (limit),
        .o_sample       (sample),
        .o_sample_valid (sample_valid),
        .o_status       (status)
    );

    // SRAM write port
    sram_writer sram_writer_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .i_sram_ready   (i_sram_ready),
        .o_sram         (o_sram),
        .o_drops        (drops)
    );

endmodule

`default_nettype wire

// ==== sim/aud_rec_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module aud_rec_properties
    import apb_pkg::*;
    import aud_pkg::*;
(
    input wire logic     i_clk,
    input wire logic     i_rst_n,
    input wire apb_req_t i_apb,
    input wire apb_rsp_t i_apb_rsp,
    input wire sram_wr_t i_sram,
    input wire logic     i_sram_ready
);

    // Held write keeps enable, address and data until accepted
    property write_held_stable;
        @(posedge i_clk) disable iff (i_rst_n)
            (i_sram.we && !i_sram_ready) |=>
                (i_sram.we && $stable(i_sram.addr) && $stable(i_sram.data));
    endproperty

    property write_idle_after_reset;
        @(posedge i_clk) i_rst_n |=> !i_sram.we;
    endproperty

    // No wait states on the register bus
    property ready_in_access;
        @(posedge i_clk) disable iff (i_rst_n)
            (i_apb.psel && i_apb.penable) |-> i_apb_rsp.pready;
    endproperty

    held_stable_a: assert property (write_held_stable)
        else $error("SRAM write changed while waiting for ready");
    idle_after_reset_a: assert property (write_idle_after_reset)
        else $error("SRAM write enable high after reset");
    ready_in_access_a: assert property (ready_in_access)
        else $error("pready low in an APB access phase");

endmodule

bind aud_rec_top aud_rec_properties aud_rec_properties_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_apb        (i_apb),
    .i_apb_rsp    (o_apb),
    .i_sram       (o_sram),
    .i_sram_ready (i_sram_ready)
);

`default_nettype wire

// ==== sim/aud_rec_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module aud_rec_tb
    import apb_pkg::*;
    import aud_pkg::*;
();

    logic     clk = 1'b0;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     lrc;
    logic     sdata;
    sram_wr_t sram;
    logic     sram_ready;

    // Words the capture rule says must reach the SRAM, in order
    sample_t  exp_q[$];
    string    test_name;
    int       low_run = 0;
    int       model_count;
    int       model_limit;
    logic     model_rec;
    logic     model_paused;
    logic     model_done;

    always #4 clk = ~clk;

    aud_rec_top aud_rec_top_i (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_apb        (apb_req),
        .o_apb        (apb_rsp),
        .i_lrc        (lrc),
        .i_data       (sdata),
        .o_sram       (sram),
        .i_sram_ready (sram_ready)
    );

    // ============================================================
    // Error handling
    // ============================================================
    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAIL %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp_val, act_val);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("ERROR in %s: %s", test_name, what);
        abort_run();
    endtask

    // ============================================================
    // SRAM model and scoreboard
    // ============================================================
    // Random ready, never low more than 3 cycles in a row
    always @(posedge clk) begin
        if (low_run >= 3 || ($urandom % 2) == 0) begin
            sram_ready <= 1'b1;
            low_run    <= 0;
        end else begin
            sram_ready <= 1'b0;
            low_run    <= low_run + 1;
        end
    end

    always @(negedge clk) begin
        if (!rst_n && sram.we && sram_ready) begin
            assert (exp_q.size() > 0)
                else report_error("SRAM write with no recorded word pending");
            if (exp_q.size() > 0) begin
                assert (sram.addr == exp_q[0].addr)
                    else report_mismatch("write address", 32'(exp_q[0].addr), 32'(sram.addr));
                assert (sram.data == exp_q[0].data)
                    else report_mismatch("write data", 32'(exp_q[0].data), 32'(sram.data));
                void'(exp_q.pop_front());
            end
        end
    end

    // ============================================================
    // APB driver
    // ============================================================
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int n;
        n = 0;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && n < 16) begin
            @(negedge clk);
            n++;
        end
        assert (apb_rsp.pready) else report_error("APB access never got pready");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        assert (err == exp_err)
            else report_mismatch($sformatf("pslverr writing 0x%02h", addr), 32'(exp_err), 32'(err));
    endtask

    task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp_data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        assert (!err)
            else report_mismatch($sformatf("pslverr reading 0x%02h", addr), 32'd0, 32'(err));
        assert (rdata == exp_data)
            else report_mismatch($sformatf("read 0x%02h", addr), exp_data, rdata);
    endtask

    task automatic reg_read_err(input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        assert (err)
            else report_mismatch($sformatf("pslverr reading 0x%02h", addr), 32'd1, 32'(err));
    endtask

    task automatic check_status();
        reg_check(REG_STATUS, {29'd0, model_done, model_paused, model_rec});
    endtask

    // CTRL write, then the expected recorder state
    task automatic send_cmd(input logic start, input logic pause, input logic stop);
        reg_write(REG_CTRL, {29'd0, stop, pause, start}, 1'b0);
        if (pause && model_rec) begin
            model_paused = !model_paused;
        end
        if (stop && model_rec) begin
            model_rec    = 1'b0;
            model_done   = 1'b1;
            model_paused = 1'b0;
        end
        if (start) begin
            model_rec    = 1'b1;
            model_paused = 1'b0;
            model_done   = 1'b0;
            model_count  = 0;
        end
        repeat (2) @(posedge clk);
    endtask

    // ============================================================
    // I2S driver
    // ============================================================
    task automatic send_word(input logic [15:0] word, input logic allow);
        sample_t s;
        if (allow && model_rec && !model_paused) begin
            s.addr = 20'(model_count);
            s.data = word;
            exp_q.push_back(s);
            model_count++;
            if (model_count >= model_limit) begin
                model_rec  = 1'b0;
                model_done = 1'b1;
            end
        end
        repeat (20) begin
            @(posedge clk);
            lrc <= 1'b1;
        end
        @(posedge clk);
        lrc <= 1'b0;
        for (int i = 15; i >= 0; i--) begin
            @(posedge clk);
            sdata <= word[i];
        end
        @(posedge clk);
        lrc <= 1'b1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 400) begin
            @(negedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else report_error("timeout waiting for SRAM writes");
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        void'($urandom(53));
        rst_n        = 1'b1;
        apb_req      = '0;
        lrc          = 1'b1;
        sdata        = 1'b0;
        sram_ready   = 1'b0;
        model_rec    = 1'b0;
        model_paused = 1'b0;
        model_done   = 1'b0;
        model_count  = 0;
        model_limit  = int'(LIMIT_RESET);
        test_name    = "reset";
        repeat (16) @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        check_status();
        reg_check(REG_LIMIT, 32'(LIMIT_RESET));
        reg_check(REG_COUNT, 32'd0);
        // Idle recorder must not write
        send_word(16'($urandom), 1'b1);
        wait_drain();

        test_name = "capture";
        send_cmd(1'b1, 1'b0, 1'b0);
        repeat (6) send_word(16'($urandom), 1'b1);
        wait_drain();
        check_status();
        reg_check(REG_COUNT, model_count);

        test_name = "backpressure";
        repeat (10) send_word(16'($urandom), 1'b1);
        wait_drain();
        reg_check(REG_DROPS, 32'd0);
        reg_check(REG_COUNT, model_count);

        test_name = "pause";
        send_cmd(1'b0, 1'b1, 1'b0);
        check_status();
        repeat (2) send_word(16'($urandom), 1'b1);
        send_cmd(1'b0, 1'b1, 1'b0);
        check_status();
        repeat (3) send_word(16'($urandom), 1'b1);
        wait_drain();
        reg_check(REG_COUNT, model_count);

        test_name = "limit";
        reg_write(REG_LIMIT, 32'd3, 1'b0);
        model_limit = 3;
        send_cmd(1'b1, 1'b0, 1'b0);
        repeat (5) send_word(16'($urandom), 1'b1);
        wait_drain();
        check_status();
        reg_check(REG_COUNT, 32'd3);

        test_name = "stop";
        send_cmd(1'b1, 1'b0, 1'b0);
        send_word(16'($urandom), 1'b1);
        // Stop lands in the middle of the data bits
        fork
            send_word(16'($urandom), 1'b0);
            begin
                repeat (26) @(posedge clk);
                send_cmd(1'b0, 1'b0, 1'b1);
            end
        join
        repeat (20) @(posedge clk);
        wait_drain();
        check_status();
        reg_check(REG_COUNT, model_count);

        test_name = "apb errors";
        reg_read_err(8'h14);
        reg_write(REG_COUNT, 32'h55, 1'b1);
        reg_write(REG_STATUS, 32'h7, 1'b1);
        reg_check(REG_COUNT, model_count);
        reg_check(REG_LIMIT, 32'd3);
        check_status();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/apb_pkg.sv
source/aud_pkg.sv
source/aud_ctrl_regs.sv
source/aud_recorder.sv
source/sram_writer.sv
source/aud_rec_top.sv
sim/aud_rec_properties.sv
sim/aud_rec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module aud_rec_tb -o aud_rec_sim

sim_out=$(./obj_dir/aud_rec_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
